// File: filelist.f
verilog/frontend_pkg.sv
verilog/entry_table.sv
verilog/mispredict_counter.sv
verilog/branch_predictor.sv
verilog/target_buffer.sv
verilog/return_stack.sv
verilog/fetch_ctrl.sv
verilog/fetch_frontend.sv
dv/fetch_frontend_asserts.sv
dv/fetch_frontend_tb.sv

// File: run.sh
#!/bin/sh
# builds the fetch front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_frontend_tb -f filelist.f -o sim_fetch_frontend
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_fetch_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

// File: dv/fetch_frontend_tb.sv
/*
  Directed testbench for the fetch front end.
  A reference model of the target buffer, prediction tables, mispredict count
  and return stack follows every fetch.
  Resolves are sent only while req is high and before ack, always for the
  block in flight and always as mispredicts.
  Ack delays and random taken bits come from an LCG seeded with 32'ha4b3.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_tb;

  logic                     clk;
  logic                     rst;
  logic                     fetch_req;
  logic                     fetch_ack;
  frontend_pkg::addr_t      fetch_addr;
  frontend_pkg::ght_t       fetch_ght;
  logic                     fetch_taken;
  logic                     resolve_valid;
  frontend_pkg::addr_t      resolve_addr;
  frontend_pkg::jump_kind_t resolve_kind;
  logic                     resolve_taken;
  frontend_pkg::addr_t      resolve_target;
  logic                     resolve_mispredict;
  frontend_pkg::ght_t       resolve_ght;

  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rng_state = 32'ha4b3;

  // reference model
  logic                                m_tb_valid  [1 << frontend_pkg::TBUF_IDX_W];
  frontend_pkg::jump_kind_t            m_tb_kind   [1 << frontend_pkg::TBUF_IDX_W];
  logic [frontend_pkg::TAG_W-1:0]      m_tb_tag    [1 << frontend_pkg::TBUF_IDX_W];
  frontend_pkg::addr_t                 m_tb_target [1 << frontend_pkg::TBUF_IDX_W];
  logic                                m_tbl [3][1 << frontend_pkg::PRED_IDX_W];
  logic [3:0]                          m_count;
  frontend_pkg::addr_t                 m_ras [frontend_pkg::RAS_DEPTH];
  logic [frontend_pkg::RAS_PTR_W-1:0]  m_ras_ptr;
  frontend_pkg::addr_t                 m_addr;
  frontend_pkg::ght_t                  m_ght;
  logic                                m_pend;
  frontend_pkg::addr_t                 m_redir_addr;
  frontend_pkg::ght_t                  m_redir_ght;

  fetch_frontend fetch_frontend_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ~1100 cycles of tests at worst, rest is margin
  initial begin
    repeat (3000) @(posedge clk);
    $display("timeout: the tests did not finish within 3000 clock cycles");
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  task automatic compare_addr(input string name, input frontend_pkg::addr_t got,
                              input frontend_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_ght(input string name, input frontend_pkg::ght_t got,
                             input frontend_pkg::ght_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // A, B, C index hashes of the prediction tables
  function automatic frontend_pkg::pred_idx_t table_index(input int tbl,
      input frontend_pkg::addr_t a, input frontend_pkg::ght_t g);
    if (tbl == 0) return {a[10:5], g[1:0]};
    if (tbl == 1) return a[12:5] ^ g[7:0];
    return {a[6:5], g[5:0]};
  endfunction

  task automatic model_reset();
    for (int i = 0; i < (1 << frontend_pkg::TBUF_IDX_W); i++) begin
      m_tb_valid[i] = 1'b0;
    end
    for (int t = 0; t < 3; t++) begin
      for (int i = 0; i < (1 << frontend_pkg::PRED_IDX_W); i++) begin
        m_tbl[t][i] = 1'b0;
      end
    end
    for (int i = 0; i < frontend_pkg::RAS_DEPTH; i++) begin
      m_ras[i] = '0;
    end
    m_count   = '0;
    m_ras_ptr = '0;
    m_addr    = frontend_pkg::RESET_ADDR;
    m_ght     = '0;
    m_pend    = 1'b0;
  endtask

  task automatic model_lookup(output logic taken, output frontend_pkg::addr_t next,
                              output frontend_pkg::ght_t nght);
    logic [frontend_pkg::TBUF_IDX_W-1:0] idx;
    frontend_pkg::addr_t                 seq;
    idx   = m_addr[10:5];
    seq   = m_addr + frontend_pkg::addr_t'(frontend_pkg::FETCH_BYTES);
    taken = 1'b0;
    next  = seq;
    nght  = m_ght;
    if (m_tb_valid[idx] && m_tb_tag[idx] == m_addr[31:11]) begin
      taken = 1'b1;
      case (m_tb_kind[idx])
        frontend_pkg::JK_UNCOND: next = m_tb_target[idx];
        frontend_pkg::JK_CALL: begin
          next                = m_tb_target[idx];
          m_ras_ptr           = m_ras_ptr + 1'b1;
          m_ras[m_ras_ptr]    = seq;
        end
        frontend_pkg::JK_RET: begin
          next      = m_ras[m_ras_ptr];
          m_ras_ptr = m_ras_ptr - 1'b1;
        end
        default: begin
          taken = m_tbl[0][table_index(0, m_addr, m_ght)] ^
                  m_tbl[1][table_index(1, m_addr, m_ght)] ^
                  m_tbl[2][table_index(2, m_addr, m_ght)];
          next  = taken ? m_tb_target[idx] : seq;
          nght  = {m_ght[frontend_pkg::GHT_W-2:0], taken};
        end
      endcase
    end
  endtask

  // mispredicted resolve of the block in flight
  task automatic model_resolve(input frontend_pkg::jump_kind_t kind, input logic taken,
                               input frontend_pkg::addr_t target);
    logic [frontend_pkg::TBUF_IDX_W-1:0] idx;
    frontend_pkg::pred_idx_t             ti;
    idx              = m_addr[10:5];
    m_tb_valid[idx]  = 1'b1;
    m_tb_kind[idx]   = kind;
    m_tb_tag[idx]    = m_addr[31:11];
    m_tb_target[idx] = target;
    if (kind == frontend_pkg::JK_COND) begin
      for (int t = 0; t < 3; t++) begin
        ti = table_index(t, m_addr, m_ght);
        if (t == 0 || (t == 1 && m_count[1:0] == 2'd0) || (t == 2 && m_count == 4'd0)) begin
          m_tbl[t][ti] = ~m_tbl[t][ti];
        end
      end
      m_count = m_count + 4'd1;
    end
    m_pend       = 1'b1;
    m_redir_addr = taken ? target : m_addr + frontend_pkg::addr_t'(frontend_pkg::FETCH_BYTES);
    m_redir_ght  = (kind == frontend_pkg::JK_COND) ?
                   {m_ght[frontend_pkg::GHT_W-2:0], taken} : m_ght;
  endtask

  task automatic wait_req();
    while (!fetch_req) @(negedge clk);
  endtask

  task automatic handshake(input int delay, output frontend_pkg::addr_t a,
                           output frontend_pkg::ght_t g, output logic t);
    wait_req();
    repeat (delay) @(negedge clk);
    a         = fetch_addr;
    g         = fetch_ght;
    t         = fetch_taken;
    fetch_ack = 1'b1;
    do @(negedge clk); while (fetch_req);
    repeat (delay) @(negedge clk);  // fetch unit drops ack late
    fetch_ack = 1'b0;
  endtask

  // one fetch checked against the model, with an optional mispredicted resolve
  task automatic fetch_step(input logic do_res, input frontend_pkg::jump_kind_t kind,
                            input logic res_taken, input frontend_pkg::addr_t target,
                            input int delay);
    logic                exp_taken;
    logic                got_taken;
    frontend_pkg::addr_t nxt;
    frontend_pkg::addr_t got_addr;
    frontend_pkg::ght_t  nght;
    frontend_pkg::ght_t  got_ght;
    model_lookup(exp_taken, nxt, nght);
    wait_req();
    if (do_res) begin
      resolve_valid      = 1'b1;
      resolve_addr       = m_addr;
      resolve_kind       = kind;
      resolve_taken      = res_taken;
      resolve_target     = target;
      resolve_mispredict = 1'b1;
      resolve_ght        = m_ght;
      model_resolve(kind, res_taken, target);
      @(negedge clk);
      resolve_valid      = 1'b0;
      resolve_mispredict = 1'b0;
    end
    handshake(delay, got_addr, got_ght, got_taken);
    compare_addr("fetch_addr", got_addr, m_addr);
    compare_ght("fetch_ght", got_ght, m_ght);
    compare_bit("fetch_taken", got_taken, exp_taken);
    m_addr = m_pend ? m_redir_addr : nxt;
    m_ght  = m_pend ? m_redir_ght : nght;
    m_pend = 1'b0;
  endtask

  task automatic fetch_plain(input int delay);
    fetch_step(1'b0, frontend_pkg::JK_COND, 1'b0, '0, delay);
  endtask

  task automatic fetch_resolved(input frontend_pkg::jump_kind_t kind, input logic taken,
                                input frontend_pkg::addr_t target);
    fetch_step(1'b1, kind, taken, target, 0);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before) tests_failed++;
    $display("test %s: %s, %0d errors", name,
             (errors == errors_before) ? "passed" : "failed", errors - errors_before);
  endtask

  task automatic test_sequential();
    int e0;
    e0 = errors;
    @(negedge clk);
    compare_bit("fetch_req", fetch_req, 1'b0);  // lookup cycle
    @(negedge clk);
    compare_bit("fetch_req", fetch_req, 1'b1);
    repeat (10) fetch_plain(0);
    report_test("sequential", e0);
  endtask

  task automatic test_uncond();
    int                  e0;
    frontend_pkg::addr_t src;
    e0  = errors;
    src = m_addr;
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, 32'h0000_8000);
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, src);
    repeat (3) fetch_plain(0);  // src, target, src again
    report_test("uncond_redirect", e0);
  endtask

  task automatic test_call_return();
    int e0;
    e0 = errors;
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, 32'h0002_0000);
    fetch_resolved(frontend_pkg::JK_CALL, 1'b1, 32'h0003_0100);
    fetch_resolved(frontend_pkg::JK_RET, 1'b1, 32'h0002_0020);
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, 32'h0002_0000);
    repeat (3) fetch_plain(0);
    // nested, two levels deep
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, 32'h0004_0000);
    fetch_resolved(frontend_pkg::JK_CALL, 1'b1, 32'h0005_0200);
    fetch_resolved(frontend_pkg::JK_CALL, 1'b1, 32'h0006_0400);
    fetch_resolved(frontend_pkg::JK_RET, 1'b1, 32'h0005_0220);
    fetch_resolved(frontend_pkg::JK_RET, 1'b1, 32'h0004_0020);
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, 32'h0004_0000);
    repeat (6) fetch_plain(0);
    report_test("call_return", e0);
  endtask

  task automatic test_cond();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, 32'h0007_0000);
    // each redirect shifts one more outcome into the history
    for (int i = 0; i < 24; i++) begin
      r = lcg_next();
      fetch_resolved(frontend_pkg::JK_COND, r[20], 32'h0007_0000);
    end
    repeat (10) fetch_plain(0);
    report_test("cond_predict", e0);
  endtask

  task automatic test_ack_delay();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, 32'h0009_0000);
    fetch_plain(0);
    fetch_plain(0);
    fetch_resolved(frontend_pkg::JK_UNCOND, 1'b1, 32'h0009_0000);
    for (int i = 0; i < 50; i++) begin
      r = lcg_next();
      fetch_plain(int'(r[18:16]));
    end
    report_test("ack_delay", e0);
  endtask

  initial begin
    rst                = 1'b1;
    fetch_ack          = 1'b0;
    resolve_valid      = 1'b0;
    resolve_addr       = '0;
    resolve_kind       = frontend_pkg::JK_COND;
    resolve_taken      = 1'b0;
    resolve_target     = '0;
    resolve_mispredict = 1'b0;
    resolve_ght        = '0;
    errors             = 0;
    checks             = 0;
    tests_run          = 0;
    tests_failed       = 0;
    model_reset();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_sequential();
    test_uncond();
    test_call_return();
    test_cond();
    test_ack_delay();
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/fetch_frontend_asserts.sv
/*
  Handshake and reset checks, bound into every fetch_frontend instance.
  Assumes ack comes from the fetch unit and follows the four-phase rule.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_asserts (
  input wire logic                clk,
  input wire logic                rst,
  input wire logic                fetch_req,
  input wire logic                fetch_ack,
  input wire frontend_pkg::addr_t fetch_addr,
  input wire frontend_pkg::ght_t  fetch_ght,
  input wire logic                fetch_taken
);

  a_req_low_in_reset: assert property (@(posedge clk) rst |=> !fetch_req)
    else $error("fetch_req high after a reset cycle");

  // request held until ack
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    fetch_req && !fetch_ack |=> fetch_req)
    else $error("fetch_req dropped before fetch_ack");

  a_values_stable: assert property (@(posedge clk) disable iff (rst)
    fetch_req && !fetch_ack |=>
      $stable(fetch_addr) && $stable(fetch_ght) && $stable(fetch_taken))
    else $error("fetch address, history or taken changed during a request");

  a_no_rise_on_ack: assert property (@(posedge clk) disable iff (rst)
    !fetch_req && fetch_ack |=> !fetch_req)
    else $error("fetch_req rose while fetch_ack was still high");

endmodule

bind fetch_frontend fetch_frontend_asserts asserts_i (.*);

`default_nettype wire

// File: verilog/fetch_frontend.sv
/*
  Fetch front end top level.
  Fetch requests use a four-phase req/ack handshake, one block at a time.
  Resolve reports are single-cycle pulses from retirement; resolve_ght must
  be the fetch_ght shown for the resolved block.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
  input  wire logic                     clk,
  input  wire logic                     rst,
  output logic                          fetch_req,
  input  wire logic                     fetch_ack,
  output frontend_pkg::addr_t           fetch_addr,
  output frontend_pkg::ght_t            fetch_ght,
  output logic                          fetch_taken,
  input  wire logic                     resolve_valid,
  input  wire frontend_pkg::addr_t      resolve_addr,
  input  wire frontend_pkg::jump_kind_t resolve_kind,
  input  wire logic                     resolve_taken,
  input  wire frontend_pkg::addr_t      resolve_target,
  input  wire logic                     resolve_mispredict,
  input  wire frontend_pkg::ght_t       resolve_ght
);

  logic                      tbuf_hit;
  frontend_pkg::tbuf_entry_t tbuf_entry;
  logic                      pred_taken;
  frontend_pkg::addr_t       ras_top;
  frontend_pkg::addr_t       ras_push_addr;
  logic                      ras_push;
  logic                      ras_pop;

  fetch_ctrl ctrl (
    .clk (clk), .rst (rst),
    .fetch_req (fetch_req), .fetch_ack (fetch_ack),
    .fetch_addr (fetch_addr), .fetch_ght (fetch_ght), .fetch_taken (fetch_taken),
    .tbuf_hit (tbuf_hit), .tbuf_entry (tbuf_entry), .pred_taken (pred_taken),
    .ras_top (ras_top), .ras_push (ras_push), .ras_push_addr (ras_push_addr),
    .ras_pop (ras_pop),
    .resolve_valid (resolve_valid), .resolve_addr (resolve_addr),
    .resolve_kind (resolve_kind), .resolve_taken (resolve_taken),
    .resolve_target (resolve_target), .resolve_mispredict (resolve_mispredict),
    .resolve_ght (resolve_ght)
  );

  branch_predictor bpred (
    .clk (clk), .rst (rst),
    .lookup_addr (fetch_addr), .lookup_ght (fetch_ght), .pred_taken (pred_taken),
    .resolve_valid (resolve_valid), .resolve_addr (resolve_addr),
    .resolve_kind (resolve_kind), .resolve_mispredict (resolve_mispredict),
    .resolve_ght (resolve_ght)
  );

  target_buffer tbuf (
    .clk (clk), .rst (rst),
    .lookup_addr (fetch_addr), .hit (tbuf_hit), .entry (tbuf_entry),
    .resolve_valid (resolve_valid), .resolve_addr (resolve_addr),
    .resolve_kind (resolve_kind), .resolve_target (resolve_target)
  );

  return_stack ras (
    .clk (clk), .rst (rst),
    .push (ras_push), .push_addr (ras_push_addr),
    .pop (ras_pop), .top (ras_top)
  );

endmodule

`default_nettype wire

// File: verilog/fetch_ctrl.sv
/*
  Fetch FSM: one lookup cycle, then a four-phase req/ack fetch request.
  Only one block is in flight; the next address is computed in lookup and
  loaded when the handshake finishes, or replaced by a pending redirect.
  Lookup waits one extra cycle while a conditional mispredict updates the
  predictor tables, so it never sees a half-updated read.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  wire logic                      clk,
  input  wire logic                      rst,
  output logic                           fetch_req,
  input  wire logic                      fetch_ack,
  output frontend_pkg::addr_t            fetch_addr,
  output frontend_pkg::ght_t             fetch_ght,
  output logic                           fetch_taken,
  input  wire logic                      tbuf_hit,
  input  wire frontend_pkg::tbuf_entry_t tbuf_entry,
  input  wire logic                      pred_taken,
  input  wire frontend_pkg::addr_t       ras_top,
  output logic                           ras_push,
  output frontend_pkg::addr_t            ras_push_addr,
  output logic                           ras_pop,
  input  wire logic                      resolve_valid,
  input  wire frontend_pkg::addr_t       resolve_addr,
  input  wire frontend_pkg::jump_kind_t  resolve_kind,
  input  wire logic                      resolve_taken,
  input  wire frontend_pkg::addr_t       resolve_target,
  input  wire logic                      resolve_mispredict,
  input  wire frontend_pkg::ght_t        resolve_ght
);

  typedef enum logic [1:0] {
    S_LOOKUP,
    S_REQ,
    S_RELEASE
  } state_t;

  state_t              state;
  logic                lk_go;
  logic                lk_taken;
  logic                redir_pending;
  frontend_pkg::addr_t seq_addr;
  frontend_pkg::addr_t lk_addr;
  frontend_pkg::addr_t next_addr;
  frontend_pkg::addr_t redir_addr;
  frontend_pkg::ght_t  lk_ght;
  frontend_pkg::ght_t  next_ght;
  frontend_pkg::ght_t  redir_ght;

  assign seq_addr      = fetch_addr + frontend_pkg::addr_t'(frontend_pkg::FETCH_BYTES);
  assign ras_push_addr = seq_addr;  // return lands on the block after the call

  assign lk_go = (state == S_LOOKUP) &&
                 !(resolve_valid && resolve_mispredict &&
                   resolve_kind == frontend_pkg::JK_COND);

  always_comb begin
    lk_addr  = seq_addr;
    lk_ght   = fetch_ght;
    lk_taken = 1'b0;
    ras_push = 1'b0;
    ras_pop  = 1'b0;
    if (tbuf_hit) begin
      case (tbuf_entry.kind)
        frontend_pkg::JK_UNCOND: begin
          lk_addr  = tbuf_entry.target;
          lk_taken = 1'b1;
        end
        frontend_pkg::JK_CALL: begin
          lk_addr  = tbuf_entry.target;
          lk_taken = 1'b1;
          ras_push = lk_go;
        end
        frontend_pkg::JK_RET: begin
          lk_addr  = ras_top;
          lk_taken = 1'b1;
          ras_pop  = lk_go;
        end
        default: begin  // conditional, only kind that shifts history
          lk_taken = pred_taken;
          lk_addr  = pred_taken ? tbuf_entry.target : seq_addr;
          lk_ght   = {fetch_ght[frontend_pkg::GHT_W-2:0], pred_taken};
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_RELEASE;  // exit from reset loads RESET_ADDR like a release
      fetch_req   <= 1'b0;
      fetch_addr  <= frontend_pkg::RESET_ADDR;
      fetch_ght   <= '0;
      fetch_taken <= 1'b0;
      next_addr   <= frontend_pkg::RESET_ADDR;
      next_ght    <= '0;
    end else begin
      case (state)
        S_LOOKUP: begin
          if (lk_go) begin
            next_addr   <= lk_addr;
            next_ght    <= lk_ght;
            fetch_taken <= lk_taken;
            fetch_req   <= 1'b1;
            state       <= S_REQ;
          end
        end
        S_REQ: begin
          if (fetch_ack) begin
            fetch_req <= 1'b0;
            state     <= S_RELEASE;
          end
        end
        default: begin
          if (!fetch_ack) begin  // handshake done
            fetch_addr <= redir_pending ? redir_addr : next_addr;
            fetch_ght  <= redir_pending ? redir_ght : next_ght;
            state      <= S_LOOKUP;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      redir_pending <= 1'b0;
    end else if (resolve_valid && resolve_mispredict) begin
      redir_pending <= 1'b1;
    end else if (state == S_RELEASE && !fetch_ack) begin
      redir_pending <= 1'b0;
    end
  end

  // last mispredict wins
  always_ff @(posedge clk) begin
    if (resolve_valid && resolve_mispredict) begin
      redir_addr <= resolve_taken ? resolve_target :
                    resolve_addr + frontend_pkg::addr_t'(frontend_pkg::FETCH_BYTES);
      redir_ght  <= (resolve_kind == frontend_pkg::JK_COND) ?
                    {resolve_ght[frontend_pkg::GHT_W-2:0], resolve_taken} : resolve_ght;
    end
  end

endmodule

`default_nettype wire

// File: verilog/return_stack.sv
/*
  Circular return address stack of RAS_DEPTH entries.
  ptr points at the top entry; push writes one above it.
  Overflow overwrites the oldest entry, underflow wraps without warning.
  Redirects do not repair the stack, it is left as it is.
*/
`timescale 1ns/1ps
`default_nettype none

module return_stack (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                push,
  input  wire frontend_pkg::addr_t push_addr,
  input  wire logic                pop,
  output frontend_pkg::addr_t      top
);

  frontend_pkg::addr_t                stack [frontend_pkg::RAS_DEPTH];
  logic [frontend_pkg::RAS_PTR_W-1:0] ptr;

  assign top = stack[ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
      for (int i = 0; i < frontend_pkg::RAS_DEPTH; i++) begin
        stack[i] <= '0;
      end
    end else if (push) begin
      stack[ptr + 1'b1] <= push_addr;
      ptr               <= ptr + 1'b1;
    end else if (pop) begin
      ptr <= ptr - 1'b1;  // entry stays, only the pointer moves
    end
  end

endmodule

`default_nettype wire

// File: verilog/target_buffer.sv
/*
  Direct-mapped jump target buffer, indexed by address bits 10:5.
  Every resolve overwrites its entry, so two jumps in one fetch block
  or two blocks sharing an index evict each other.
  A hit is valid and tag match only; kind and target come from the entry.
*/
`timescale 1ns/1ps
`default_nettype none

module target_buffer (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire frontend_pkg::addr_t      lookup_addr,
  output logic                          hit,
  output frontend_pkg::tbuf_entry_t     entry,
  input  wire logic                     resolve_valid,
  input  wire frontend_pkg::addr_t      resolve_addr,
  input  wire frontend_pkg::jump_kind_t resolve_kind,
  input  wire frontend_pkg::addr_t      resolve_target
);

  logic [frontend_pkg::TBUF_IDX_W-1:0] lk_idx;
  logic [frontend_pkg::TBUF_IDX_W-1:0] wr_idx;
  logic [frontend_pkg::TAG_W-1:0]      lk_tag;
  frontend_pkg::tbuf_entry_t           wr_entry;

  assign lk_idx = lookup_addr[frontend_pkg::OFFS_W +: frontend_pkg::TBUF_IDX_W];
  assign lk_tag = lookup_addr[frontend_pkg::OFFS_W + frontend_pkg::TBUF_IDX_W +:
                              frontend_pkg::TAG_W];
  assign wr_idx = resolve_addr[frontend_pkg::OFFS_W +: frontend_pkg::TBUF_IDX_W];

  assign hit = entry.valid && (entry.tag == lk_tag);

  // full entry on every resolve
  assign wr_entry = '{
    valid:  1'b1,
    kind:   resolve_kind,
    tag:    resolve_addr[frontend_pkg::OFFS_W + frontend_pkg::TBUF_IDX_W +:
                         frontend_pkg::TAG_W],
    target: resolve_target
  };

  entry_table #(
    .entry_t (frontend_pkg::tbuf_entry_t),
    .IDX_W   (frontend_pkg::TBUF_IDX_W)
  ) tbuf_table (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (lk_idx),
    .rd_data (entry),
    .wr_en   (resolve_valid),
    .wr_idx  (wr_idx),
    .wr_data (wr_entry)
  );

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
/*
  Three one-bit prediction tables, hashed from address and global history,
  XORed into one taken bit.
  Only a mispredicted conditional resolve updates them: A always flips,
  B and C flip when the mispredict counter allows.
  While an update is in progress the tables are read at the update index,
  so pred_taken is meaningless in that cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire frontend_pkg::addr_t      lookup_addr,
  input  wire frontend_pkg::ght_t       lookup_ght,
  output logic                          pred_taken,
  input  wire logic                     resolve_valid,
  input  wire frontend_pkg::addr_t      resolve_addr,
  input  wire frontend_pkg::jump_kind_t resolve_kind,
  input  wire logic                     resolve_mispredict,
  input  wire frontend_pkg::ght_t       resolve_ght
);

  function automatic frontend_pkg::pred_idx_t hash_a(input frontend_pkg::addr_t addr,
                                                     input frontend_pkg::ght_t ght);
    return {addr[10:5], ght[1:0]};
  endfunction

  function automatic frontend_pkg::pred_idx_t hash_b(input frontend_pkg::addr_t addr,
                                                     input frontend_pkg::ght_t ght);
    return addr[12:5] ^ ght[7:0];
  endfunction

  function automatic frontend_pkg::pred_idx_t hash_c(input frontend_pkg::addr_t addr,
                                                     input frontend_pkg::ght_t ght);
    return {addr[6:5], ght[5:0]};
  endfunction

  logic upd;
  logic upd_b;
  logic upd_c;
  logic bit_a;
  logic bit_b;
  logic bit_c;
  frontend_pkg::pred_idx_t rd_idx_a;
  frontend_pkg::pred_idx_t rd_idx_b;
  frontend_pkg::pred_idx_t rd_idx_c;

  assign upd = resolve_valid && resolve_mispredict && (resolve_kind == frontend_pkg::JK_COND);

  // second index path, old bits come back for the flip
  assign rd_idx_a = upd ? hash_a(resolve_addr, resolve_ght) : hash_a(lookup_addr, lookup_ght);
  assign rd_idx_b = upd ? hash_b(resolve_addr, resolve_ght) : hash_b(lookup_addr, lookup_ght);
  assign rd_idx_c = upd ? hash_c(resolve_addr, resolve_ght) : hash_c(lookup_addr, lookup_ght);

  assign pred_taken = bit_a ^ bit_b ^ bit_c;

  mispredict_counter mp_count (
    .clk             (clk),
    .rst             (rst),
    .cond_mispredict (upd),
    .upd_b           (upd_b),
    .upd_c           (upd_c)
  );

  entry_table #(.entry_t(logic), .IDX_W(frontend_pkg::PRED_IDX_W)) table_a (
    .clk (clk), .rst (rst),
    .rd_idx (rd_idx_a), .rd_data (bit_a),
    .wr_en (upd), .wr_idx (rd_idx_a), .wr_data (~bit_a)
  );

  entry_table #(.entry_t(logic), .IDX_W(frontend_pkg::PRED_IDX_W)) table_b (
    .clk (clk), .rst (rst),
    .rd_idx (rd_idx_b), .rd_data (bit_b),
    .wr_en (upd_b), .wr_idx (rd_idx_b), .wr_data (~bit_b)
  );

  entry_table #(.entry_t(logic), .IDX_W(frontend_pkg::PRED_IDX_W)) table_c (
    .clk (clk), .rst (rst),
    .rd_idx (rd_idx_c), .rd_data (bit_c),
    .wr_en (upd_c), .wr_idx (rd_idx_c), .wr_data (~bit_c)
  );

endmodule

`default_nettype wire

// File: verilog/mispredict_counter.sv
/*
  Counts conditional mispredicts in a 4-bit wrapping counter.
  upd_b and upd_c decode the count before this event's increment:
  B every 4th event, C every 16th, starting with the first after reset.
*/
`timescale 1ns/1ps
`default_nettype none

module mispredict_counter (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic cond_mispredict,
  output logic      upd_b,
  output logic      upd_c
);

  logic [3:0] count;

  // valid only while an event is present
  assign upd_b = cond_mispredict && (count[1:0] == 2'd0);
  assign upd_c = cond_mispredict && (count == 4'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (cond_mispredict) begin
      count <= count + 4'd1;  // wraps at 16
    end
  end

endmodule

`default_nettype wire

// File: verilog/entry_table.sv
/*
  Register table with one combinational read port and one write port.
  All entries clear on reset.
  A write lands at the clock edge, so a read of the same index in the
  write cycle still returns the old entry.
*/
`timescale 1ns/1ps
`default_nettype none

module entry_table #(
  parameter type entry_t = logic,
  parameter int  IDX_W   = 8
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic [IDX_W-1:0] rd_idx,
  output entry_t                rd_data,
  input  wire logic             wr_en,
  input  wire logic [IDX_W-1:0] wr_idx,
  input  wire entry_t           wr_data
);

  entry_t mem [(1 << IDX_W)];

  assign rd_data = mem[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < (1 << IDX_W); i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/frontend_pkg.sv
/*
  Widths, reset address and types shared by the fetch front end.
  Fetch blocks are FETCH_BYTES long and aligned, so bits OFFS_W-1:0 of a fetch
  address are always zero.
  TAG_W + TBUF_IDX_W + OFFS_W must equal ADDR_W.
  RAS_DEPTH must be 2**RAS_PTR_W because the return stack pointer wraps.
*/
`default_nettype none

package frontend_pkg;

  localparam int ADDR_W      = 32;
  localparam int FETCH_BYTES = 32;
  localparam int OFFS_W      = 5;   // log2 of FETCH_BYTES
  localparam int GHT_W       = 14;
  localparam int PRED_IDX_W  = 8;
  localparam int TBUF_IDX_W  = 6;
  localparam int TAG_W       = ADDR_W - TBUF_IDX_W - OFFS_W;
  localparam int RAS_DEPTH   = 8;
  localparam int RAS_PTR_W   = 3;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [GHT_W-1:0]      ght_t;  // newest outcome in bit 0
  typedef logic [PRED_IDX_W-1:0] pred_idx_t;

  localparam addr_t RESET_ADDR = 32'h0000_1000;

  typedef enum logic [1:0] {
    JK_COND   = 2'd0,
    JK_UNCOND = 2'd1,
    JK_CALL   = 2'd2,
    JK_RET    = 2'd3
  } jump_kind_t;

  // one jump target buffer entry
  typedef struct packed {
    logic             valid;
    jump_kind_t       kind;
    logic [TAG_W-1:0] tag;     // address bits 31:11
    addr_t            target;
  } tbuf_entry_t;

endpackage

`default_nettype wire
